//--- tmr_settings.svh
// --------------------------------------------------------------------------
// TMR control unit settings
// Widths of the data word, mismatch counters and register address, and
// the redundancy mode taken out of reset
// --------------------------------------------------------------------------

`ifndef TMR_SETTINGS_SVH
`define TMR_SETTINGS_SVH

// Core data word and register data
`define TMR_DATA_W 32
// Per-core mismatch counter
`define TMR_CNT_W 8
// Register address
`define TMR_ADDR_W 3
// Reset mode, 0 starts independent and 1 starts in redundant run
`define TMR_DEFAULT_ON 0

`endif

//--- tmr_pkg.sv
// --------------------------------------------------------------------------
// TMR control unit package
// Mode encoding, register map and the per-core control record
// --------------------------------------------------------------------------

`default_nettype none

`include "tmr_settings.svh"

package tmr_pkg;

  // Redundancy mode of the core group
  typedef enum logic [1:0] {NON_TMR, TMR_RUN, TMR_UNLOAD, TMR_RELOAD} tmr_mode_e;

  // Software register map
  typedef enum logic [`TMR_ADDR_W-1:0] {
    ADDR_ENABLE   = 3'd0,
    ADDR_CONFIG   = 3'd1,
    ADDR_SP_STORE = 3'd2,
    ADDR_MODE     = 3'd3,
    ADDR_CNT0     = 3'd4,
    ADDR_CNT1     = 3'd5,
    ADDR_CNT2     = 3'd6
  } tmr_addr_e;

  // Core store control, write enable plus byte strobes
  typedef struct packed {
    logic       we;
    logic [3:0] be;
  } core_ctrl_t;

  // Core data word and counter value
  typedef logic [`TMR_DATA_W-1:0] tmr_word_t;
  typedef logic [`TMR_CNT_W-1:0]  tmr_cnt_t;

endpackage

`default_nettype wire

//--- tmr_voter.sv
// --------------------------------------------------------------------------
// Three-way majority voter
// Forwards the value held by at least two cores and flags each core
// that differs from it; reports failure when all three disagree
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tmr_voter import tmr_pkg::*; #(
  parameter type payload_t = core_ctrl_t
) (
  input  payload_t   a_i,
  input  payload_t   b_i,
  input  payload_t   c_i,
  output payload_t   voted_o,
  output logic [2:0] err_o,
  output logic       fail_o
);

  logic ab_eq;
  logic ac_eq;
  logic bc_eq;

  // Whole-payload pairwise compares
  assign ab_eq = (a_i == b_i);
  assign ac_eq = (a_i == c_i);
  assign bc_eq = (b_i == c_i);

  always_comb begin
    // Core a is the majority whenever it agrees with anyone
    voted_o = a_i;
    err_o   = 3'b000;
    fail_o  = 1'b0;
    if (ab_eq && ac_eq) begin
      // All three agree
      err_o = 3'b000;
    end else if (ab_eq) begin
      err_o[2] = 1'b1;
    end else if (ac_eq) begin
      err_o[1] = 1'b1;
    end else if (bc_eq) begin
      voted_o  = b_i;
      err_o[0] = 1'b1;
    end else begin
      // No majority, pass core a and flag nobody
      fail_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- tmr_regs.sv
// --------------------------------------------------------------------------
// TMR software register file
// Enable, configuration and stack-pointer store registers on a plain
// write-strobe bus with combinational read; reports mode and counters
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "tmr_settings.svh"

module tmr_regs import tmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Register bus
  input  logic                   reg_we_i,
  input  tmr_addr_e              reg_addr_i,
  input  logic [`TMR_DATA_W-1:0] reg_wdata_i,
  output logic [`TMR_DATA_W-1:0] reg_rdata_o,
  // From control and counters
  input  logic                   force_ack_i,
  input  tmr_mode_e              mode_i,
  input  tmr_cnt_t               cnt0_i,
  input  tmr_cnt_t               cnt1_i,
  input  tmr_cnt_t               cnt2_i,
  // To control
  output logic                   enable_o,
  output logic                   delay_resynch_o,
  output logic                   setback_en_o,
  output logic                   reload_setback_en_o,
  output logic                   force_resynch_o,
  output logic                   sp_store_set_o,
  output logic                   sp_store_zero_wr_o,
  // Counter clear pulses
  output logic [2:0]             cnt_clr_o
);

  logic                   we_enable;
  logic                   we_config;
  logic                   we_sp_store;
  logic                   enable_q;
  logic                   delay_resynch_q;
  logic                   setback_q;
  logic                   reload_setback_q;
  logic                   force_resynch_q;
  logic [`TMR_DATA_W-1:0] sp_store_q;

  // Write decode
  assign we_enable   = reg_we_i && (reg_addr_i == ADDR_ENABLE);
  assign we_config   = reg_we_i && (reg_addr_i == ADDR_CONFIG);
  assign we_sp_store = reg_we_i && (reg_addr_i == ADDR_SP_STORE);

  // Any write to a counter address clears that counter
  assign cnt_clr_o[0] = reg_we_i && (reg_addr_i == ADDR_CNT0);
  assign cnt_clr_o[1] = reg_we_i && (reg_addr_i == ADDR_CNT1);
  assign cnt_clr_o[2] = reg_we_i && (reg_addr_i == ADDR_CNT2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Enable starts in the default mode so the group stays there
      enable_q         <= 1'(`TMR_DEFAULT_ON);
      delay_resynch_q  <= 1'b0;
      setback_q        <= 1'b0;
      reload_setback_q <= 1'b0;
      force_resynch_q  <= 1'b0;
      sp_store_q       <= '0;
    end else begin
      if (we_enable) begin
        enable_q <= reg_wdata_i[0];
      end
      if (we_config) begin
        delay_resynch_q  <= reg_wdata_i[0];
        setback_q        <= reg_wdata_i[1];
        reload_setback_q <= reg_wdata_i[2];
        // A write setting the bit wins over an ack in the same cycle
        force_resynch_q  <= reg_wdata_i[3];
      end else if (force_ack_i) begin
        force_resynch_q <= 1'b0;
      end
      if (we_sp_store) begin
        sp_store_q <= reg_wdata_i;
      end
    end
  end

  assign enable_o            = enable_q;
  assign delay_resynch_o     = delay_resynch_q;
  assign setback_en_o        = setback_q;
  assign reload_setback_en_o = reload_setback_q;
  assign force_resynch_o     = force_resynch_q;

  // Nonzero sp_store flags a finished unload
  assign sp_store_set_o      = (sp_store_q != '0);
  // Zero write marks the end of reload in this very cycle
  assign sp_store_zero_wr_o  = we_sp_store && (reg_wdata_i == '0);

  // Read mux, unmapped addresses return zero
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      ADDR_ENABLE:   reg_rdata_o[0] = enable_q;
      ADDR_CONFIG:   reg_rdata_o[3:0] = {force_resynch_q, reload_setback_q,
                                         setback_q, delay_resynch_q};
      ADDR_SP_STORE: reg_rdata_o = sp_store_q;
      ADDR_MODE:     reg_rdata_o[1:0] = mode_i;
      ADDR_CNT0:     reg_rdata_o[`TMR_CNT_W-1:0] = cnt0_i;
      ADDR_CNT1:     reg_rdata_o[`TMR_CNT_W-1:0] = cnt1_i;
      ADDR_CNT2:     reg_rdata_o[`TMR_CNT_W-1:0] = cnt2_i;
      default:       reg_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- tmr_ctrl.sv
// --------------------------------------------------------------------------
// TMR mode controller
// Merges voter reports, counts single-core mismatches and steps the group
// through independent, run, unload and reload modes with setback pulses
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "tmr_settings.svh"

module tmr_ctrl import tmr_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Voter reports
  input  logic [2:0] data_err_i,
  input  logic [2:0] ctrl_err_i,
  input  logic       data_fail_i,
  input  logic       ctrl_fail_i,
  // Core group status
  input  logic       fetch_en_i,
  input  logic       cores_synch_i,
  // Register levels and pulses
  input  logic       enable_i,
  input  logic       delay_resynch_i,
  input  logic       setback_en_i,
  input  logic       reload_setback_en_i,
  input  logic       force_resynch_i,
  input  logic       sp_store_set_i,
  input  logic       sp_store_zero_wr_i,
  // Back to registers and counters
  output tmr_mode_e  mode_o,
  output logic       force_ack_o,
  output logic [2:0] incr_o,
  // Group outputs
  output logic [2:0] tmr_error_o,
  output logic       tmr_failure_o,
  output logic       setback_o,
  output logic       resynch_req_o,
  output logic       grp_in_independent_o
);

  localparam tmr_mode_e default_mode = (`TMR_DEFAULT_ON != 0) ? TMR_RUN : NON_TMR;

  tmr_mode_e mode_d;
  tmr_mode_e mode_q;
  logic      setback_d;
  logic      setback_q;
  logic      multi_err;
  logic      single_mismatch;

  // Merge both voters
  assign tmr_error_o     = data_err_i | ctrl_err_i;
  // More than one core flagged
  assign multi_err       = (tmr_error_o[0] & tmr_error_o[1]) |
                           (tmr_error_o[0] & tmr_error_o[2]) |
                           (tmr_error_o[1] & tmr_error_o[2]);
  assign single_mismatch = (|tmr_error_o) && !multi_err;
  assign tmr_failure_o   = data_fail_i || ctrl_fail_i || multi_err;

  always_comb begin
    mode_d      = mode_q;
    setback_d   = 1'b0;
    force_ack_o = 1'b0;
    incr_o      = 3'b000;

    case (mode_q)
      TMR_RUN: begin
        // Forced resync is acked even while delayed
        if (force_resynch_i) begin
          force_ack_o = 1'b1;
          if (!delay_resynch_i) begin
            mode_d = TMR_UNLOAD;
          end
        end
        // Count the odd core out and resync it
        if (single_mismatch) begin
          incr_o = tmr_error_o;
          if (!delay_resynch_i) begin
            mode_d = TMR_UNLOAD;
          end
        end
      end
      TMR_UNLOAD: begin
        // Software stored its state, reload with optional core reset
        if (sp_store_set_i) begin
          mode_d    = TMR_RELOAD;
          setback_d = setback_en_i;
        end
      end
      TMR_RELOAD: begin
        if (!sp_store_set_i) begin
          mode_d = TMR_RUN;
        end else if ((single_mismatch || tmr_failure_o) && setback_en_i &&
                     reload_setback_en_i && !sp_store_zero_wr_i) begin
          // Error during reload, restart it
          setback_d = 1'b1;
        end
      end
      default: begin
        mode_d = mode_q;
      end
    endcase

    // Before cores fetch, mode follows the enable bit
    if (!fetch_en_i) begin
      mode_d = enable_i ? TMR_RUN : NON_TMR;
    end
    // Leaving redundancy is allowed any time during run
    if (mode_q == TMR_RUN && !enable_i) begin
      mode_d = NON_TMR;
    end
    // Cores report being in step, join the group
    if (mode_q == NON_TMR && cores_synch_i && enable_i) begin
      mode_d = TMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= default_mode;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign mode_o               = mode_q;
  assign setback_o            = setback_q;
  assign resynch_req_o        = (mode_q == TMR_UNLOAD);
  assign grp_in_independent_o = (mode_q == NON_TMR);

endmodule

`default_nettype wire

//--- tmr_mismatch_cnt.sv
// --------------------------------------------------------------------------
// Per-core mismatch counters
// Three saturating counters bumped by the controller, cleared by software
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tmr_mismatch_cnt import tmr_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [2:0] incr_i,
  input  logic [2:0] clr_i,
  output tmr_cnt_t   cnt0_o,
  output tmr_cnt_t   cnt1_o,
  output tmr_cnt_t   cnt2_o
);

  tmr_cnt_t cnt_q [3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 3; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        // Clear wins over a same-cycle increment
        if (clr_i[i]) begin
          cnt_q[i] <= '0;
        end else if (incr_i[i] && (cnt_q[i] != '1)) begin
          // Hold at all ones
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign cnt0_o = cnt_q[0];
  assign cnt1_o = cnt_q[1];
  assign cnt2_o = cnt_q[2];

endmodule

`default_nettype wire

//--- tmr_unit.sv
// --------------------------------------------------------------------------
// TMR control unit top level
// Register file, data and control voters, mode controller and
// mismatch counters for a group of three lockstepped cores
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "tmr_settings.svh"

module tmr_unit import tmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Register bus
  input  logic                   reg_we_i,
  input  tmr_addr_e              reg_addr_i,
  input  logic [`TMR_DATA_W-1:0] reg_wdata_i,
  output logic [`TMR_DATA_W-1:0] reg_rdata_o,
  // Core group
  input  logic                   fetch_en_i,
  input  logic                   cores_synch_i,
  input  logic [`TMR_DATA_W-1:0] core_data0_i,
  input  logic [`TMR_DATA_W-1:0] core_data1_i,
  input  logic [`TMR_DATA_W-1:0] core_data2_i,
  input  core_ctrl_t             core_ctrl0_i,
  input  core_ctrl_t             core_ctrl1_i,
  input  core_ctrl_t             core_ctrl2_i,
  // Voted result and status
  output logic [`TMR_DATA_W-1:0] voted_data_o,
  output core_ctrl_t             voted_ctrl_o,
  output logic [2:0]             tmr_error_o,
  output logic                   tmr_failure_o,
  output logic                   setback_o,
  output logic                   resynch_req_o,
  output logic                   grp_in_independent_o
);

  logic       enable;
  logic       delay_resynch;
  logic       setback_en;
  logic       reload_setback_en;
  logic       force_resynch;
  logic       sp_store_set;
  logic       sp_store_zero_wr;
  logic       force_ack;
  tmr_mode_e  mode;
  logic [2:0] data_err;
  logic [2:0] ctrl_err;
  logic       data_fail;
  logic       ctrl_fail;
  logic [2:0] incr;
  logic [2:0] cnt_clr;
  tmr_cnt_t   cnt0;
  tmr_cnt_t   cnt1;
  tmr_cnt_t   cnt2;

  // Software view
  tmr_regs u_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .reg_we_i            (reg_we_i),
    .reg_addr_i          (reg_addr_i),
    .reg_wdata_i         (reg_wdata_i),
    .reg_rdata_o         (reg_rdata_o),
    .force_ack_i         (force_ack),
    .mode_i              (mode),
    .cnt0_i              (cnt0),
    .cnt1_i              (cnt1),
    .cnt2_i              (cnt2),
    .enable_o            (enable),
    .delay_resynch_o     (delay_resynch),
    .setback_en_o        (setback_en),
    .reload_setback_en_o (reload_setback_en),
    .force_resynch_o     (force_resynch),
    .sp_store_set_o      (sp_store_set),
    .sp_store_zero_wr_o  (sp_store_zero_wr),
    .cnt_clr_o           (cnt_clr)
  );

  // Data word vote
  tmr_voter #(
    .payload_t (tmr_word_t)
  ) u_data_voter (
    .a_i     (core_data0_i),
    .b_i     (core_data1_i),
    .c_i     (core_data2_i),
    .voted_o (voted_data_o),
    .err_o   (data_err),
    .fail_o  (data_fail)
  );

  // Store control vote
  tmr_voter #(
    .payload_t (core_ctrl_t)
  ) u_ctrl_voter (
    .a_i     (core_ctrl0_i),
    .b_i     (core_ctrl1_i),
    .c_i     (core_ctrl2_i),
    .voted_o (voted_ctrl_o),
    .err_o   (ctrl_err),
    .fail_o  (ctrl_fail)
  );

  tmr_ctrl u_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .data_err_i           (data_err),
    .ctrl_err_i           (ctrl_err),
    .data_fail_i          (data_fail),
    .ctrl_fail_i          (ctrl_fail),
    .fetch_en_i           (fetch_en_i),
    .cores_synch_i        (cores_synch_i),
    .enable_i             (enable),
    .delay_resynch_i      (delay_resynch),
    .setback_en_i         (setback_en),
    .reload_setback_en_i  (reload_setback_en),
    .force_resynch_i      (force_resynch),
    .sp_store_set_i       (sp_store_set),
    .sp_store_zero_wr_i   (sp_store_zero_wr),
    .mode_o               (mode),
    .force_ack_o          (force_ack),
    .incr_o               (incr),
    .tmr_error_o          (tmr_error_o),
    .tmr_failure_o        (tmr_failure_o),
    .setback_o            (setback_o),
    .resynch_req_o        (resynch_req_o),
    .grp_in_independent_o (grp_in_independent_o)
  );

  // Mismatch statistics
  tmr_mismatch_cnt u_mismatch_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .incr_i (incr),
    .clr_i  (cnt_clr),
    .cnt0_o (cnt0),
    .cnt1_o (cnt1),
    .cnt2_o (cnt2)
  );

endmodule

`default_nettype wire

//--- tmr_unit_checker.sv
// --------------------------------------------------------------------------
// TMR control unit protocol checker
// Concurrent assertions on the top level ports: setback is a single
// cycle pulse, resync and independent mode exclude each other, and the
// mismatch counters hold while the group runs independent
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "tmr_settings.svh"

module tmr_unit_checker import tmr_pkg::*; (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   reg_we_i,
  input tmr_addr_e              reg_addr_i,
  input logic [`TMR_DATA_W-1:0] reg_rdata_i,
  input logic                   setback_i,
  input logic                   resynch_req_i,
  input logic                   grp_in_independent_i
);

  // Failed assertions, read back by the testbench
  int unsigned fail_cnt = 0;

  // Core reset lasts exactly one cycle
  setback_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    setback_i |=> !setback_i)
    else begin
      $error("setback_o high on two consecutive cycles");
      fail_cnt++;
    end

  // Resync is only requested from a redundant mode
  resynch_not_independent: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(resynch_req_i && grp_in_independent_i))
    else begin
      $error("resynch_req_o and grp_in_independent_o both high");
      fail_cnt++;
    end

  // Same counter address on two cycles, no clear write in between
  cnt_hold_independent: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(grp_in_independent_i) && !$past(reg_we_i) && $stable(reg_addr_i) &&
     (reg_addr_i inside {ADDR_CNT0, ADDR_CNT1, ADDR_CNT2}))
    |-> $stable(reg_rdata_i))
    else begin
      $error("mismatch counter changed in independent mode");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- tmr_unit_tb.sv
// --------------------------------------------------------------------------
// TMR control unit testbench
// Table of register ops, core group levels and core corruption applied
// one row per cycle; checks voted outputs, status and mode against the
// expected values held in each row
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "tmr_settings.svh"

module tmr_unit_tb import tmr_pkg::*; ();

  localparam int CLK_PERIOD = 10;

  // Register op of a row
  localparam logic [1:0] OP_ID = 2'd0;
  localparam logic [1:0] OP_WR = 2'd1;
  localparam logic [1:0] OP_RD = 2'd2;

  // Cores whose data word is inverted, ALL gives three distinct words
  localparam logic [2:0] OK  = 3'b000;
  localparam logic [2:0] C1  = 3'b010;
  localparam logic [2:0] ALL = 3'b111;

  typedef struct {
    logic [1:0]             op;
    tmr_addr_e              addr;
    logic [`TMR_DATA_W-1:0] wdata;
    logic                   fetch_en;
    logic                   cores_synch;
    logic [2:0]             corrupt;
    tmr_mode_e              exp_mode;
    logic [`TMR_DATA_W-1:0] exp_rdata;
    logic [2:0]             exp_err;
    logic                   exp_fail;
    logic                   exp_setback;
    logic                   exp_resynch;
  } row_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   reg_we_i;
  tmr_addr_e              reg_addr_i;
  logic [`TMR_DATA_W-1:0] reg_wdata_i;
  logic [`TMR_DATA_W-1:0] reg_rdata_o;
  logic                   fetch_en_i;
  logic                   cores_synch_i;
  logic [`TMR_DATA_W-1:0] core_data0_i;
  logic [`TMR_DATA_W-1:0] core_data1_i;
  logic [`TMR_DATA_W-1:0] core_data2_i;
  core_ctrl_t             core_ctrl0_i;
  core_ctrl_t             core_ctrl1_i;
  core_ctrl_t             core_ctrl2_i;
  logic [`TMR_DATA_W-1:0] voted_data_o;
  core_ctrl_t             voted_ctrl_o;
  logic [2:0]             tmr_error_o;
  logic                   tmr_failure_o;
  logic                   setback_o;
  logic                   resynch_req_o;
  logic                   grp_in_independent_o;

  row_t                   rows[$];
  int                     cur_row;
  int unsigned            err_cnt;
  logic [`TMR_DATA_W-1:0] lfsr_q;

  tmr_unit tmr_unit_inst (.*);

  bind tmr_unit tmr_unit_checker u_checker (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .reg_we_i             (reg_we_i),
    .reg_addr_i           (reg_addr_i),
    .reg_rdata_i          (reg_rdata_o),
    .setback_i            (setback_o),
    .resynch_req_i        (resynch_req_o),
    .grp_in_independent_i (grp_in_independent_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [`TMR_DATA_W-1:0] lfsr_step(input logic [`TMR_DATA_W-1:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [`TMR_DATA_W-1:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[`TMR_DATA_W-2:0], lfsr_q[0]};
    end
  endtask

  task automatic add_row(input logic [1:0] op, input tmr_addr_e addr,
                         input logic [`TMR_DATA_W-1:0] wdata, input logic fetch_en,
                         input logic synch, input logic [2:0] corrupt, input tmr_mode_e m,
                         input logic [`TMR_DATA_W-1:0] rdata, input logic [2:0] err,
                         input logic fail, input logic sb, input logic rq);
    row_t r;
    r.op          = op;
    r.addr        = addr;
    r.wdata       = wdata;
    r.fetch_en    = fetch_en;
    r.cores_synch = synch;
    r.corrupt     = corrupt;
    r.exp_mode    = m;
    r.exp_rdata   = rdata;
    r.exp_err     = err;
    r.exp_fail    = fail;
    r.exp_setback = sb;
    r.exp_resynch = rq;
    rows.push_back(r);
  endtask

  // Mode, setback and resync are the registered values seen in that row
  task automatic build_table();
    // Reset state, register read back
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_MODE,     32'h0,         0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_WR, ADDR_CONFIG,   32'h6,         0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_CONFIG,   32'h0,         0, 0, OK,  NON_TMR,    32'h6, 3'b000, 0, 0, 0);
    add_row(OP_WR, ADDR_SP_STORE, 32'h1234_5678, 0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_SP_STORE, 32'h0,  0, 0, OK, NON_TMR, 32'h1234_5678, 3'b000, 0, 0, 0);
    add_row(OP_WR, ADDR_SP_STORE, 32'h0,         0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_SP_STORE, 32'h0,         0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    // Enable with fetch low, mode follows enable
    add_row(OP_WR, ADDR_ENABLE,   32'h1,         0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_MODE,     32'h0,         0, 0, OK,  TMR_RUN,    32'h1, 3'b000, 0, 0, 0);
    add_row(OP_WR, ADDR_ENABLE,   32'h0,         0, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         0, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_MODE,     32'h0,         0, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    // Fetching cores rejoin only on cores_synch
    add_row(OP_WR, ADDR_ENABLE,   32'h1,         1, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         1, 0, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         1, 1, OK,  NON_TMR,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_MODE,     32'h0,         1, 0, OK,  TMR_RUN,    32'h1, 3'b000, 0, 0, 0);
    // Core 1 mismatch with delayed resync
    add_row(OP_WR, ADDR_CONFIG,   32'h7,         1, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         1, 0, C1,  TMR_RUN,    32'h0, 3'b010, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         1, 0, C1,  TMR_RUN,    32'h1, 3'b010, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         1, 0, OK,  TMR_RUN,    32'h2, 3'b000, 0, 0, 0);
    // Without delay a mismatch starts the unload
    add_row(OP_WR, ADDR_CONFIG,   32'h6,         1, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         1, 0, C1,  TMR_RUN,    32'h2, 3'b010, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         1, 0, OK,  TMR_UNLOAD, 32'h3, 3'b000, 0, 0, 1);
    add_row(OP_RD, ADDR_MODE,     32'h0,         1, 0, OK,  TMR_UNLOAD, 32'h2, 3'b000, 0, 0, 1);
    // Stored state triggers reload and one setback cycle
    add_row(OP_WR, ADDR_SP_STORE, 32'h100,       1, 0, OK,  TMR_UNLOAD, 32'h0, 3'b000, 0, 0, 1);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         1, 0, OK,  TMR_UNLOAD, 32'h0, 3'b000, 0, 0, 1);
    add_row(OP_RD, ADDR_MODE,     32'h0,         1, 0, OK,  TMR_RELOAD, 32'h3, 3'b000, 0, 1, 0);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         1, 0, OK,  TMR_RELOAD, 32'h0, 3'b000, 0, 0, 0);
    add_row(OP_WR, ADDR_SP_STORE, 32'h0,         1, 0, OK,  TMR_RELOAD, 32'h0, 3'b000, 0, 0, 0);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         1, 0, OK,  TMR_RELOAD, 32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_MODE,     32'h0,         1, 0, OK,  TMR_RUN,    32'h1, 3'b000, 0, 0, 0);
    // No majority, counters untouched
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         1, 0, ALL, TMR_RUN,    32'h0, 3'b000, 1, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         1, 0, ALL, TMR_RUN,    32'h3, 3'b000, 1, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         1, 0, OK,  TMR_RUN,    32'h3, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT0,     32'h0,         1, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT2,     32'h0,         1, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    // Counter clear, then forced resync
    add_row(OP_WR, ADDR_CNT1,     32'hFFFF_FFFF, 1, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         1, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_WR, ADDR_CONFIG,   32'hE,         1, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_CONFIG,   32'h0,         1, 0, OK,  TMR_RUN,    32'hE, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_CONFIG,   32'h0,         1, 0, OK,  TMR_UNLOAD, 32'h6, 3'b000, 0, 0, 1);
    add_row(OP_RD, ADDR_MODE,     32'h0,         1, 0, OK,  TMR_UNLOAD, 32'h2, 3'b000, 0, 0, 1);
    add_row(OP_ID, ADDR_ENABLE,   32'h0,         1, 0, OK,  TMR_UNLOAD, 32'h0, 3'b000, 0, 0, 1);
    // Back to independent, mismatches there leave the counters alone
    add_row(OP_WR, ADDR_ENABLE,   32'h0,         0, 0, OK,  TMR_UNLOAD, 32'h0, 3'b000, 0, 0, 1);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         0, 0, OK,  TMR_RUN,    32'h0, 3'b000, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         0, 0, C1,  NON_TMR,    32'h0, 3'b010, 0, 0, 0);
    add_row(OP_RD, ADDR_CNT1,     32'h0,         0, 0, C1,  NON_TMR,    32'h0, 3'b010, 0, 0, 0);
  endtask

  task automatic check_mode(input string name, input tmr_mode_e got, input tmr_mode_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED row %0d: %s got 0x%0h expected 0x%0h", cur_row, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input logic [`TMR_DATA_W-1:0] got,
                            input logic [`TMR_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED row %0d: %s got 0x%0h expected 0x%0h", cur_row, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_err(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED row %0d: %s got 0x%0h expected 0x%0h", cur_row, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_ctrl(input string name, input core_ctrl_t got, input core_ctrl_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED row %0d: %s got 0x%0h expected 0x%0h", cur_row, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED row %0d: %s got 0x%0h expected 0x%0h", cur_row, name, got, exp);
      err_cnt++;
    end
  endtask

  // Called right after a rising edge
  task automatic drive_row(input row_t r, input logic [`TMR_DATA_W-1:0] base,
                           input core_ctrl_t ctrl);
    reg_we_i      <= (r.op == OP_WR);
    reg_addr_i    <= r.addr;
    reg_wdata_i   <= r.wdata;
    fetch_en_i    <= r.fetch_en;
    cores_synch_i <= r.cores_synch;
    core_ctrl0_i  <= ctrl;
    core_ctrl1_i  <= ctrl;
    core_ctrl2_i  <= ctrl;
    core_data0_i  <= base;
    if (r.corrupt == ALL) begin
      // Three words that pairwise differ
      core_data1_i <= ~base;
      core_data2_i <= base ^ 32'h5A5A_0000;
    end else begin
      core_data1_i <= r.corrupt[1] ? ~base : base;
      core_data2_i <= r.corrupt[2] ? ~base : base;
    end
  endtask

  // Called at the falling edge, outputs have settled
  task automatic check_row(input row_t r, input logic [`TMR_DATA_W-1:0] base,
                           input core_ctrl_t ctrl);
    check_mode("mode", tmr_unit_inst.mode, r.exp_mode);
    check_word("voted_data_o", voted_data_o, base);
    check_ctrl("voted_ctrl_o", voted_ctrl_o, ctrl);
    check_err("tmr_error_o", tmr_error_o, r.exp_err);
    check_flag("tmr_failure_o", tmr_failure_o, r.exp_fail);
    check_flag("setback_o", setback_o, r.exp_setback);
    check_flag("resynch_req_o", resynch_req_o, r.exp_resynch);
    check_flag("grp_in_independent_o", grp_in_independent_o, r.exp_mode == NON_TMR);
    if (r.op == OP_RD) begin
      check_word("reg_rdata_o", reg_rdata_o, r.exp_rdata);
    end
  endtask

  initial begin
    logic [`TMR_DATA_W-1:0] base;
    logic [`TMR_DATA_W-1:0] ctrl_bits;
    int unsigned            assert_cnt;
    build_table();
    err_cnt       = 0;
    cur_row       = 0;
    lfsr_q        = 32'd61;
    rst_ni        = 1'b0;
    reg_we_i      = 1'b0;
    reg_addr_i    = ADDR_ENABLE;
    reg_wdata_i   = '0;
    fetch_en_i    = 1'b0;
    cores_synch_i = 1'b0;
    core_data0_i  = '0;
    core_data1_i  = '0;
    core_data2_i  = '0;
    core_ctrl0_i  = '0;
    core_ctrl1_i  = '0;
    core_ctrl2_i  = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (rows[i]) begin
      @(posedge clk_i);
      cur_row = i;
      take_bits(`TMR_DATA_W, base);
      take_bits(5, ctrl_bits);
      drive_row(rows[i], base, core_ctrl_t'(ctrl_bits[4:0]));
      @(negedge clk_i);
      check_row(rows[i], base, core_ctrl_t'(ctrl_bits[4:0]));
    end
    // One more edge so the last row's assertions are evaluated
    @(posedge clk_i);
    @(negedge clk_i);
    assert_cnt = tmr_unit_inst.u_checker.fail_cnt;
    $display("Errors: %0d compare, %0d assertion", err_cnt, assert_cnt);
    if (err_cnt == 0 && assert_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Ten cycles per row plus margin for reset
  initial begin
    #1;
    repeat (rows.size() * 10 + 100) @(posedge clk_i);
    $display("Watchdog expired, the run took longer than the table allows");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
tmr_pkg.sv
tmr_voter.sv
tmr_regs.sv
tmr_ctrl.sv
tmr_mismatch_cnt.sv
tmr_unit.sv
tmr_unit_checker.sv
tmr_unit_tb.sv

//--- Bender.yml
package:
  name: tmr_unit

sources:
  - include_dirs:
      - .
    files:
      - tmr_pkg.sv
      - tmr_voter.sv
      - tmr_regs.sv
      - tmr_ctrl.sv
      - tmr_mismatch_cnt.sv
      - tmr_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tmr_unit_checker.sv
      - tmr_unit_tb.sv
